// ==== genesis_cart_macros.svh ====
/*
 * Cartridge loader constants: bus widths, header field addresses,
 * cheat code index, region codes and quirk flag positions
 */
`ifndef GENESIS_CART_MACROS_SVH
`define GENESIS_CART_MACROS_SVH

// Host and ROM bus widths
`define CART_DATA_W        16
`define CART_ADDR_W        25

// Header byte addresses
`define HDR_REGION_ADDR    25'h1F0 // Region letters or hex digit
`define HDR_REGION2_ADDR   25'h1F2 // Extra region letter
`define HDR_END_ADDR       25'h200 // Header complete
`define ID_FIRST_ADDR      25'h182 // First product ID word
`define ID_MATCH_ADDR      25'h18C // Word that triggers the table match

`define CODE_INDEX         8'hFF   // Download index of cheat codes

// Region codes, also the bit positions of the header flags
`define REGION_JP          2'd0
`define REGION_US          2'd1
`define REGION_EU          2'd2

// Quirk flag bits
`define QUIRK_SRAM         0
`define QUIRK_EEPROM       1
`define QUIRK_NORAM        2
`define QUIRK_FIFO         3
`define QUIRK_PIER         4
`define QUIRK_SVP          5
`define QUIRK_FMBUSY       6
`define QUIRK_SCHAN        7

`endif

// ==== genesis_cart_pkg.sv ====
/*
 * Cartridge loader types shared by the control and datapath blocks
 */
`include "genesis_cart_macros.svh"

package genesis_cart_pkg;

	// Host word and byte address
	typedef logic [`CART_DATA_W-1:0] cart_word_t;
	typedef logic [`CART_ADDR_W-1:0] cart_addr_t;

	// Word address toward ROM memory, byte address without bit 0
	typedef logic [`CART_ADDR_W-2:0] rom_addr_t;

	// 0 JP, 1 US, 2 EU
	typedef logic [1:0] region_t;

	// 0 US>EU>JP, 1 EU>US>JP, 2 US>JP>EU, 3 JP>US>EU
	typedef logic [1:0] region_prio_t;

	// sram, eeprom, noram, fifo, pier, svp, fmbusy, schan from bit 0 up
	typedef logic [7:0] quirk_t;

	// Eight ASCII characters, first one in the top byte
	typedef logic [63:0] product_id_t;

	// Flags 127:96, address 95:64, compare 63:32, replace 31:0
	typedef logic [127:0] cheat_rec_t;

	// ROM write handshake
	typedef enum logic {
		IDLE,
		WAIT_ACK
	} load_state_t;

endpackage

// ==== cart_word_if.sv ====
/*
 * Classified download words, from the load control to the datapaths
 */
interface cart_word_if;
	import genesis_cart_pkg::*;

	logic       cart_wr;  // Cartridge word strobe
	logic       code_wr;  // Cheat code word strobe
	cart_addr_t addr;
	cart_word_t data;
	logic       dl_start; // Cartridge download began
	logic       dl_end;   // Cartridge download finished

	modport source (
		output cart_wr, code_wr, addr, data, dl_start, dl_end
	);

	modport sink (
		input cart_wr, code_wr, addr, data, dl_start, dl_end
	);

endinterface

// ==== cart_load_ctrl.sv ====
/*
 * Download control: classifies host words, flags download edges,
 * writes cartridge words to ROM with a toggle handshake and stalls the host
 */
`include "genesis_cart_macros.svh"

module cart_load_ctrl (
	input  logic                         clk_sys,
	input  logic                         RESET,
	input  logic                         ioctl_download,
	input  logic                         ioctl_wr,
	input  logic [7:0]                   ioctl_index,
	input  genesis_cart_pkg::cart_addr_t ioctl_addr,
	input  genesis_cart_pkg::cart_word_t ioctl_data,
	input  logic                         rom_ack,
	output logic                         ioctl_wait,
	output logic                         rom_req,
	output genesis_cart_pkg::rom_addr_t  rom_addr,
	output genesis_cart_pkg::cart_word_t rom_wdata,
	output genesis_cart_pkg::cart_addr_t rom_size,
	cart_word_if.source                  bus
);
	import genesis_cart_pkg::*;

	load_state_t state;
	logic        code_sel;
	logic        cart_dl;
	logic        accept;
	logic        dl_q;      // Registered cartridge download level
	logic        dl_prev;
	logic        dl_fall;
	cart_addr_t  last_addr; // Address of the latest cartridge word

	assign code_sel = (ioctl_index == `CODE_INDEX);
	assign cart_dl  = ioctl_download & ~code_sel;
	assign accept   = (state == IDLE) & cart_dl & ioctl_wr;

	//////////////////////////////////////////////////////////////////////
	// Input stage toward the datapaths

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			bus.cart_wr <= 1'b0;
			bus.code_wr <= 1'b0;
			dl_q        <= 1'b0;
			dl_prev     <= 1'b0;
		end else begin
			bus.cart_wr <= cart_dl & ioctl_wr;
			bus.code_wr <= ioctl_download & code_sel & ioctl_wr;
			dl_q        <= cart_dl;
			dl_prev     <= dl_q;
		end
	end

	always_ff @(posedge clk_sys) begin
		bus.addr <= ioctl_addr;
		bus.data <= ioctl_data;
	end

	assign dl_fall      = dl_prev & ~dl_q;
	assign bus.dl_start = dl_q & ~dl_prev;
	assign bus.dl_end   = dl_fall;

	//////////////////////////////////////////////////////////////////////
	// ROM write handshake

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			state   <= IDLE;
			rom_req <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (accept) begin
						state   <= WAIT_ACK;
						rom_req <= ~rom_req; // One toggle per word
					end
				end
				WAIT_ACK: begin
					if (rom_ack == rom_req)
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	assign ioctl_wait = (state == WAIT_ACK);

	// Held stable for the memory until the ack comes back
	always_ff @(posedge clk_sys) begin
		if (accept) begin
			rom_addr  <= ioctl_addr[`CART_ADDR_W-1:1];
			rom_wdata <= {ioctl_data[7:0], ioctl_data[15:8]}; // Byte swap
			last_addr <= ioctl_addr;
		end
		if (dl_fall)
			rom_size <= last_addr;
	end

endmodule

// ==== cart_region_detect.sv ====
/*
 * Header region decoder, picks a console region by priority order
 * once the header has been loaded
 */
`include "genesis_cart_macros.svh"

module cart_region_detect (
	input  logic                           clk_sys,
	input  logic                           RESET,
	cart_word_if.sink                      bus,
	input  logic                           region_auto,
	input  genesis_cart_pkg::region_prio_t region_prio,
	output genesis_cart_pkg::region_t      region,
	output logic                           region_valid
);
	import genesis_cart_pkg::*;

	logic [2:0] hdr_flags; // {E, U, J}, indexed by region code
	logic       hdr_end_wr;

	// One flag for J, U or E, nothing for any other character
	function automatic logic [2:0] letter_flags(input logic [7:0] c);
		logic [2:0] f;
		f = 3'b000;
		case (c)
			"J": f[`REGION_JP] = 1'b1;
			"U": f[`REGION_US] = 1'b1;
			"E": f[`REGION_EU] = 1'b1;
			default: f = 3'b000;
		endcase
		return f;
	endfunction

	// First header byte: a letter adds one flag, a hex digit sets all three
	function automatic logic [2:0] first_flags(input logic [7:0] c, input logic [2:0] cur);
		logic [2:0] lf;
		logic [7:0] h;
		lf = letter_flags(c);
		h  = c - 8'd7;
		if (lf != 3'b000)
			return cur | lf;
		else if (c >= "0" && c <= "9")
			return {c[3], c[2], c[0]};
		else if (c >= "A" && c <= "F")
			return {h[3], h[2], h[0]};
		else
			return cur;
	endfunction

	function automatic region_t pick_region(input region_prio_t prio, input logic [2:0] flags);
		region_t order [3];
		region_t pick;
		case (prio)
			2'd0:    order = '{`REGION_US, `REGION_EU, `REGION_JP};
			2'd1:    order = '{`REGION_EU, `REGION_US, `REGION_JP};
			2'd2:    order = '{`REGION_US, `REGION_JP, `REGION_EU};
			default: order = '{`REGION_JP, `REGION_US, `REGION_EU};
		endcase
		pick = order[0]; // No flag at all
		// Walk backwards so the highest flagged entry wins
		for (int i = 2; i >= 0; i--) begin
			if (flags[order[i]])
				pick = order[i];
		end
		return pick;
	endfunction

	assign hdr_end_wr = bus.cart_wr && (bus.addr == `HDR_END_ADDR);

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			hdr_flags    <= 3'b000;
			region_valid <= 1'b0;
		end else if (bus.dl_start) begin
			hdr_flags <= 3'b000;
		end else if (bus.dl_end) begin
			region_valid <= 1'b0;
		end else if (bus.cart_wr) begin
			case (bus.addr)
				`HDR_REGION_ADDR:
					hdr_flags <= first_flags(bus.data[7:0], hdr_flags)
						| letter_flags(bus.data[15:8]);
				`HDR_REGION2_ADDR:
					hdr_flags <= hdr_flags | letter_flags(bus.data[7:0]);
				`HDR_END_ADDR:
					region_valid <= region_auto;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (hdr_end_wr)
			region <= pick_region(region_prio, hdr_flags);
	end

endmodule

// ==== cart_quirk_match.sv ====
/*
 * Product ID capture and match against the table of cartridges
 * that need special handling
 */
`include "genesis_cart_macros.svh"

module cart_quirk_match (
	input  logic                     clk_sys,
	input  logic                     RESET,
	cart_word_if.sink                bus,
	output genesis_cart_pkg::quirk_t quirks
);
	import genesis_cart_pkg::*;

	// Short IDs padded with spaces
	localparam product_id_t id_table [10] = '{
		"T-081276", // Football title
		"T-81406 ", // Basketball title
		"MK-1215 ", // Boxing title
		"G-4060  ", // Wonder Boy
		"T-113016", // Puggsy
		"T-89016 ", // Clue
		"T-574023", // Pier Solar
		"MK-1229 ", // Virtua Racing
		"T-35036 ", // Hellfire
		"T-68???-"  // Game no Kanzume
	};

	localparam int id_quirk [10] = '{
		`QUIRK_SRAM, `QUIRK_SRAM, `QUIRK_EEPROM, `QUIRK_EEPROM, `QUIRK_NORAM,
		`QUIRK_FIFO, `QUIRK_PIER, `QUIRK_SVP, `QUIRK_FMBUSY, `QUIRK_SCHAN
	};

	product_id_t cart_id;
	quirk_t      id_hits;

	//////////////////////////////////////////////////////////////////////
	// ID capture in header byte order

	always_ff @(posedge clk_sys) begin
		if (bus.cart_wr) begin
			case (bus.addr)
				`ID_FIRST_ADDR:          cart_id[63:56] <= bus.data[15:8];
				`ID_FIRST_ADDR + 25'd2:  cart_id[55:40] <= {bus.data[7:0], bus.data[15:8]};
				`ID_FIRST_ADDR + 25'd4:  cart_id[39:24] <= {bus.data[7:0], bus.data[15:8]};
				`ID_FIRST_ADDR + 25'd6:  cart_id[23:8]  <= {bus.data[7:0], bus.data[15:8]};
				`ID_FIRST_ADDR + 25'd8:  cart_id[7:0]   <= bus.data[7:0];
				default: ;
			endcase
		end
	end

	always_comb begin
		id_hits = '0;
		for (int i = 0; i < 10; i++) begin
			if (cart_id == id_table[i])
				id_hits[id_quirk[i]] = 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Quirk flags

	always_ff @(posedge clk_sys) begin
		if (RESET)
			quirks <= '0;
		else if (bus.dl_start)
			quirks <= '0; // New cartridge
		else if (bus.cart_wr && (bus.addr == `ID_MATCH_ADDR))
			quirks <= quirks | id_hits;
	end

endmodule

// ==== cheat_code_loader.sv ====
/*
 * Cheat code assembly, eight words into one record with a commit strobe
 */
module cheat_code_loader (
	input  logic                         clk_sys,
	input  logic                         RESET,
	cart_word_if.sink                    bus,
	output genesis_cart_pkg::cheat_rec_t cheat_rec,
	output logic                         cheat_valid,
	output logic                         cheat_clear
);

	// Word placement by byte offset within the code
	always_ff @(posedge clk_sys) begin
		if (bus.code_wr) begin
			case (bus.addr[3:0])
				4'd0:  cheat_rec[111:96]  <= bus.data; // Flags low
				4'd2:  cheat_rec[127:112] <= bus.data; // Flags high
				4'd4:  cheat_rec[79:64]   <= bus.data; // Address low
				4'd6:  cheat_rec[95:80]   <= bus.data;
				4'd8:  cheat_rec[47:32]   <= bus.data; // Compare low
				4'd10: cheat_rec[63:48]   <= bus.data;
				4'd12: cheat_rec[15:0]    <= bus.data; // Replace low
				4'd14: cheat_rec[31:16]   <= bus.data;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cheat_valid <= 1'b0;
			cheat_clear <= 1'b0;
		end else begin
			// Record complete with the replace high word
			cheat_valid <= bus.code_wr && (bus.addr[3:0] == 4'd14);
			// First word of the code file drops earlier codes
			cheat_clear <= bus.code_wr && (bus.addr == '0);
		end
	end

endmodule

// ==== cart_loader_top.sv ====
/*
 * Cartridge loader top: download control plus region, quirk and cheat datapaths
 */
module cart_loader_top (
	input  logic                           clk_sys,
	input  logic                           RESET,
	input  logic                           ioctl_download,
	input  logic                           ioctl_wr,
	input  logic [7:0]                     ioctl_index,
	input  genesis_cart_pkg::cart_addr_t   ioctl_addr,
	input  genesis_cart_pkg::cart_word_t   ioctl_data,
	output logic                           ioctl_wait,
	output logic                           rom_req,
	input  logic                           rom_ack,
	output genesis_cart_pkg::rom_addr_t    rom_addr,
	output genesis_cart_pkg::cart_word_t   rom_wdata,
	output genesis_cart_pkg::cart_addr_t   rom_size,
	input  logic                           region_auto,
	input  genesis_cart_pkg::region_prio_t region_prio,
	output genesis_cart_pkg::region_t      region,
	output logic                           region_valid,
	output genesis_cart_pkg::quirk_t       quirks,
	output genesis_cart_pkg::cheat_rec_t   cheat_rec,
	output logic                           cheat_valid,
	output logic                           cheat_clear
);

	cart_word_if u_cart_bus ();

	cart_load_ctrl u_cart_load_ctrl (
		.clk_sys        (clk_sys),
		.RESET          (RESET),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_data     (ioctl_data),
		.rom_ack        (rom_ack),
		.ioctl_wait     (ioctl_wait),
		.rom_req        (rom_req),
		.rom_addr       (rom_addr),
		.rom_wdata      (rom_wdata),
		.rom_size       (rom_size),
		.bus            (u_cart_bus.source)
	);

	cart_region_detect u_cart_region_detect (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.bus          (u_cart_bus.sink),
		.region_auto  (region_auto),
		.region_prio  (region_prio),
		.region       (region),
		.region_valid (region_valid)
	);

	cart_quirk_match u_cart_quirk_match (
		.clk_sys (clk_sys),
		.RESET   (RESET),
		.bus     (u_cart_bus.sink),
		.quirks  (quirks)
	);

	cheat_code_loader u_cheat_code_loader (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.bus         (u_cart_bus.sink),
		.cheat_rec   (cheat_rec),
		.cheat_valid (cheat_valid),
		.cheat_clear (cheat_clear)
	);

endmodule

// ==== cart_loader_assert.sv ====
/*
 * ROM handshake and cheat strobe rules, bound into the load control
 * and the cheat loader
 */
module cart_loader_assert (
	input logic clk_sys,
	input logic RESET,
	input logic ioctl_wait,
	input logic rom_req,
	input logic rom_ack,
	input logic cheat_valid,
	input logic cheat_clear
);
	timeunit 1ns;
	timeprecision 1ps;

	// New request only from an idle handshake
	req_from_idle: assert property (@(posedge clk_sys) disable iff (RESET)
		$changed(rom_req) |-> $past(!ioctl_wait))
		else $error("rom_req toggled while ioctl_wait was high");

	wait_until_ack: assert property (@(posedge clk_sys) disable iff (RESET)
		ioctl_wait && (rom_ack != rom_req) |=> ioctl_wait)
		else $error("ioctl_wait dropped before rom_ack matched rom_req");

	wait_after_reset: assert property (@(posedge clk_sys) $past(RESET) |-> !ioctl_wait)
		else $error("ioctl_wait high after reset");

	valid_one_cycle: assert property (@(posedge clk_sys) disable iff (RESET)
		cheat_valid |=> !cheat_valid)
		else $error("cheat_valid longer than one cycle");

	clear_one_cycle: assert property (@(posedge clk_sys) disable iff (RESET)
		cheat_clear |=> !cheat_clear)
		else $error("cheat_clear longer than one cycle");

endmodule

bind cart_load_ctrl cart_loader_assert u_ctrl_assert (
	.clk_sys (clk_sys), .RESET (RESET), .ioctl_wait (ioctl_wait), .rom_req (rom_req),
	.rom_ack (rom_ack), .cheat_valid (1'b0), .cheat_clear (1'b0)
);

bind cheat_code_loader cart_loader_assert u_cheat_assert (
	.clk_sys (clk_sys), .RESET (RESET), .ioctl_wait (1'b0), .rom_req (1'b0),
	.rom_ack (1'b0), .cheat_valid (cheat_valid), .cheat_clear (cheat_clear)
);

// ==== tb_cart_loader.sv ====
/*
 * Testbench for the cartridge loader that loads random ROM images and cheat codes
 * and checks them against a reference model of the header and quirk rules
 */
`include "genesis_cart_macros.svh"

module tb_cart_loader;
	timeunit 1ns;
	timeprecision 1ps;
	import genesis_cart_pkg::*;

	logic         clk_sys, RESET;
	logic         ioctl_download, ioctl_wr, rom_ack, region_auto;
	logic [7:0]   ioctl_index;
	cart_addr_t   ioctl_addr, rom_size;
	cart_word_t   ioctl_data, rom_wdata;
	region_prio_t region_prio;
	logic         ioctl_wait, rom_req, region_valid, cheat_valid, cheat_clear;
	rom_addr_t    rom_addr;
	region_t      region;
	quirk_t       quirks;
	cheat_rec_t   cheat_rec;

	logic [31:0] rng_state = 32'd39290;
	logic [7:0]  image [0:1023]; // Byte image of the current cartridge
	logic        exp_req;        // Expected rom_req level
	int          err_count = 0;
	int          test_errs = 0;
	int          tests_run = 0;
	int          tests_failed = 0;

	string id_table [10] = '{"T-081276", "T-81406 ", "MK-1215 ", "G-4060  ", "T-113016",
		"T-89016 ", "T-574023", "MK-1229 ", "T-35036 ", "T-68???-"};
	int    id_flag [10] = '{0, 0, 1, 1, 2, 3, 4, 5, 6, 7}; // Quirk bit per entry

	cart_loader_top u_cart_loader_top (.*);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	////////////////////////////////////////////////////////////////////
	// Random numbers and reference model

	function automatic logic [31:0] rand_below(input logic [31:0] n);
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return (rng_state >> 8) % n;
	endfunction

	// Region letter to {E, U, J}
	function automatic logic [2:0] letter_bits(input logic [7:0] c);
		return (c == "J") ? 3'b001 : (c == "U") ? 3'b010 : (c == "E") ? 3'b100 : 3'b000;
	endfunction

	// Bits 3, 2 and 0 of a hex digit value give E, U and J
	function automatic logic [2:0] expect_flags(input logic [7:0] b0, b1, b2);
		logic [2:0] f;
		logic [3:0] v; // Value of the hex digit
		f = letter_bits(b0);
		if (f == 3'b000 && b0 >= "0" && b0 <= "9") begin
			v = b0 - "0";
			f = {v[3], v[2], v[0]};
		end else if (f == 3'b000 && b0 >= "A" && b0 <= "F") begin
			v = b0 - "A" + 8'd10;
			f = {v[3], v[2], v[0]};
		end
		return f | letter_bits(b1) | letter_bits(b2);
	endfunction

	function automatic logic [1:0] expect_region(input logic [1:0] prio, input logic [2:0] f);
		logic [5:0] ord; // First choice in the top bits
		case (prio)
			2'd0:    ord = {2'd1, 2'd2, 2'd0};
			2'd1:    ord = {2'd2, 2'd1, 2'd0};
			2'd2:    ord = {2'd1, 2'd0, 2'd2};
			default: ord = {2'd0, 2'd1, 2'd2};
		endcase
		if (f[ord[3:2]] && !f[ord[5:4]])
			return ord[3:2];
		if (f[ord[1:0]] && !f[ord[5:4]] && !f[ord[3:2]])
			return ord[1:0];
		return ord[5:4];
	endfunction

	// Letter, digit, hex digit or any byte
	function automatic logic [7:0] header_char();
		logic [23:0] letters;
		letters = "JUE";
		case (rand_below(4))
			0:       return letters >> (8 * rand_below(3));
			1:       return 8'h30 + rand_below(10);
			2:       return 8'h41 + rand_below(6);
			default: return rand_below(256);
		endcase
	endfunction

	// Memory side acks each toggle after 0 to 5 cycles
	initial begin : mem_responder
		int unsigned delay;
		rom_ack = 1'b0;
		forever begin
			@(negedge clk_sys);
			if (rom_req != rom_ack) begin
				delay = rand_below(6);
				repeat (delay) @(negedge clk_sys);
				rom_ack = rom_req;
			end
		end
	end

	////////////////////////////////////////////////////////////////////
	// Checks and host bus

	task automatic check_eq(input string name, input logic [127:0] got, input logic [127:0] exp);
		assert (got === exp) else begin
			$display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
			test_errs++;
			err_count++;
		end
	endtask

	task automatic report(input string msg);
		$display("error at %0t: %s", $time, msg);
		test_errs++;
		err_count++;
	endtask

	task automatic test_done(input string name);
		tests_run++;
		if (test_errs != 0)
			tests_failed++;
		$display("%-14s %s (%0d errors)", name, (test_errs == 0) ? "ok" : "FAILED", test_errs);
		test_errs = 0;
	endtask

	// Writes one host word and follows the ROM handshake of cartridge words
	task automatic host_write(input cart_addr_t a, input cart_word_t d, input logic cart);
		int t;
		ioctl_addr = a;
		ioctl_data = d;
		ioctl_wr = 1'b1;
		@(negedge clk_sys);
		ioctl_wr = 1'b0;
		if (cart) begin
			exp_req = ~exp_req;
			check_eq("ioctl_wait", ioctl_wait, 1'b1);
			check_eq("rom_req", rom_req, exp_req);
			check_eq("rom_addr", rom_addr, a >> 1);
			check_eq("rom_wdata", rom_wdata, {d[7:0], d[15:8]});
			t = 0;
			while (ioctl_wait && t < 20) begin
				@(negedge clk_sys);
				t++;
			end
			assert (!ioctl_wait) else report("ioctl_wait never released");
			assert (rom_ack == rom_req) else report("ioctl_wait released before rom_ack");
		end else begin
			@(negedge clk_sys);
		end
	endtask

	task automatic load_cart(input int pass);
		int         n, pick, t;
		cart_addr_t a;
		logic [2:0] flags;
		quirk_t     exp_q;
		n = 257 + rand_below(48); // Always past the header end
		region_auto = (pass == 0) ? 1'b1 : (pass == 1) ? 1'b0 : rand_below(2);
		region_prio = rand_below(4);
		for (int i = 0; i < 1024; i++)
			image[i] = rand_below(256);
		pick = (pass == 0) ? rand_below(10) : rand_below(11);
		for (int i = 0; i < 8; i++) begin
			if (pick < 10)
				image['h183 + i] = id_table[pick].getc(i);
			else
				image['h183 + i] = (i == 0) ? "X" : 8'h30 + rand_below(10); // No match
		end
		exp_q = (pick < 10) ? (8'b1 << id_flag[pick]) : 8'h00;
		image['h1F0] = header_char();
		image['h1F1] = header_char();
		image['h1F2] = header_char();
		flags = expect_flags(image['h1F0], image['h1F1], image['h1F2]);

		ioctl_index = 8'h00;
		ioctl_download = 1'b1;
		repeat (2) @(negedge clk_sys);
		check_eq("quirks", quirks, 8'h00); // Cleared by the new download
		for (int w = 0; w < n; w++) begin
			a = 2 * w;
			host_write(a, {image[a + 1], image[a]}, 1'b1);
			if (a == `ID_MATCH_ADDR)
				check_eq("quirks", quirks, exp_q);
			if (a == `HDR_END_ADDR) begin
				t = 0;
				while (region_auto && !region_valid && t < 10) begin
					@(negedge clk_sys);
					t++;
				end
				check_eq("region_valid", region_valid, region_auto);
				if (region_auto)
					check_eq("region", region, expect_region(region_prio, flags));
			end
		end
		ioctl_download = 1'b0;
		repeat (2) @(negedge clk_sys);
		check_eq("rom_size", rom_size, 2 * (n - 1));
		check_eq("region_valid", region_valid, 1'b0);
		test_done($sformatf("cart load %0d", pass));
	endtask

	task automatic load_codes();
		cart_word_t w [8];
		int         t;
		ioctl_index = `CODE_INDEX;
		ioctl_download = 1'b1;
		@(negedge clk_sys);
		for (int c = 0; c < 2; c++) begin
			for (int k = 0; k < 8; k++) begin
				w[k] = rand_below(65536);
				host_write(16 * c + 2 * k, w[k], 1'b0);
				if (c == 0 && k == 0) begin
					t = 0;
					while (!cheat_clear && t < 8) begin
						@(negedge clk_sys);
						t++;
					end
					assert (cheat_clear) else report("no cheat_clear after the word at address 0");
				end
			end
			t = 0;
			while (!cheat_valid && t < 8) begin
				@(negedge clk_sys);
				t++;
			end
			assert (cheat_valid) else report("cheat_valid did not pulse after offset 14");
			check_eq("cheat_rec", cheat_rec, {w[1], w[0], w[3], w[2], w[5], w[4], w[7], w[6]});
			test_done($sformatf("cheat code %0d", c));
		end
		ioctl_download = 1'b0;
		@(negedge clk_sys);
	endtask

	////////////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		RESET = 1'b1;
		ioctl_download = 1'b0;
		ioctl_wr = 1'b0;
		ioctl_index = 8'h00;
		ioctl_addr = '0;
		ioctl_data = '0;
		region_auto = 1'b0;
		region_prio = 2'd0;
		exp_req = 1'b0;
		repeat (3) @(negedge clk_sys);
		RESET = 1'b0;
		check_eq("ioctl_wait", ioctl_wait, 1'b0);
		check_eq("rom_req", rom_req, 1'b0);
		check_eq("region_valid", region_valid, 1'b0);
		check_eq("quirks", quirks, 8'h00);
		check_eq("cheat_valid", cheat_valid, 1'b0);
		check_eq("cheat_clear", cheat_clear, 1'b0);
		test_done("reset");
		for (int p = 0; p < 4; p++)
			load_cart(p);
		load_codes();
		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
		if (err_count == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== sim.f ====
+incdir+.
genesis_cart_pkg.sv
cart_word_if.sv
cart_load_ctrl.sv
cart_region_detect.sv
cart_quirk_match.sv
cheat_code_loader.sv
cart_loader_top.sv
cart_loader_assert.sv
tb_cart_loader.sv

// ==== Bender.yml ====
package:
  name: genesis_cart_loader

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - genesis_cart_pkg.sv
      - cart_word_if.sv
      - cart_load_ctrl.sv
      - cart_region_detect.sv
      - cart_quirk_match.sv
      - cheat_code_loader.sv
      - cart_loader_top.sv
      - target: test
        files:
          - cart_loader_assert.sv
          - tb_cart_loader.sv
